// ==== src/fpm_config.svh ====
`ifndef FPM_CONFIG_SVH
`define FPM_CONFIG_SVH

// bus and register word width
// also the width of one ieee single word
`define FPM_DATA_W 32

// word address width of the slave port
// enough for the five mapped registers
`define FPM_ADDR_W 3

// multiplier pipeline depth
// unpack, significand product, normalize and pack
`define FPM_STAGES 3

`endif

// ==== src/fp_pkg.sv ====
`default_nettype none

`include "fpm_config.svh"

package fp_pkg;

	// ieee single layout, msb first
	typedef struct packed {
		logic        sign;
		logic [7:0]  exp;
		logic [22:0] frac;
	} fp_fields_t;

	// one operand word, raw on the bus side and split into fields in the multiplier
	typedef union packed {
		logic [`FPM_DATA_W-1:0] raw;
		fp_fields_t             f;
	} fp_word_u;

	// status register layout, overflow in the top bit
	typedef struct packed {
		logic overflow;
		logic underflow;
		logic zero;
		logic nan;
	} fp_flags_t;

	// canonical quiet nan
	localparam logic [`FPM_DATA_W-1:0] FP_QNAN = 32'h7FC00000;
	// all-ones exponent, inf or nan
	localparam logic [7:0] FP_EXP_MAX = 8'hFF;
	// exponent bias, wide enough for the unbiased sum
	localparam logic [9:0] FP_BIAS = 10'd127;

endpackage

`default_nettype wire

// ==== src/avs_pkg.sv ====
`default_nettype none

`include "fpm_config.svh"

package avs_pkg;

	// word addresses of the peripheral registers
	// codes 5 to 7 are unmapped
	typedef enum logic [`FPM_ADDR_W-1:0] {
		MM_OP1    = 3'd0,
		MM_OP2    = 3'd1,
		MM_START  = 3'd2,
		MM_RESULT = 3'd3,
		MM_STATUS = 3'd4
	} mm_reg_e;

	// strobes from the controller to the register bank
	typedef struct packed {
		// write of OP1 this cycle
		logic ld_op1;
		// write of OP2 this cycle
		logic ld_op2;
		// product in flight, read back through START
		logic busy;
		// capture product and flags into RESULT and STATUS
		logic ld_result;
	} reg_ctrl_t;

endpackage

`default_nettype wire

// ==== src/fp_mult.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpm_config.svh"

module fp_mult import fp_pkg::*; (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic i_start,
	input  fp_word_u  i_a,
	input  fp_word_u  i_b,
	output logic      o_valid,
	output fp_word_u  o_result,
	output fp_flags_t o_flags
);

	// valid tag, bit n set when stage n+1 holds an item
	logic [`FPM_STAGES-1:0] vld_q;

	// operand classes
	logic a_zero, a_inf, a_nan;
	logic b_zero, b_inf, b_nan;

	// stage 1 registers
	logic        s1_sign, s1_nan, s1_inf, s1_zero;
	logic [8:0]  s1_exp_sum;
	logic [23:0] s1_man_a, s1_man_b;

	// stage 2 registers
	logic        s2_sign, s2_nan, s2_inf, s2_zero;
	logic [8:0]  s2_exp_sum;
	logic [47:0] s2_prod;

	// stage 3 combinational
	logic      norm;
	logic [9:0] exp_adj;
	logic [9:0] exp_unb;
	logic      ovf, unf;
	fp_word_u  res_d;
	fp_flags_t flags_d;

	// subnormals count as zero
	function automatic logic is_zero(fp_fields_t f);
		return f.exp == 8'd0;
	endfunction

	function automatic logic is_inf(fp_fields_t f);
		return (f.exp == FP_EXP_MAX) && (f.frac == 23'd0);
	endfunction

	function automatic logic is_nan(fp_fields_t f);
		return (f.exp == FP_EXP_MAX) && (f.frac != 23'd0);
	endfunction

	assign a_zero = is_zero(i_a.f);
	assign a_inf  = is_inf(i_a.f);
	assign a_nan  = is_nan(i_a.f);
	assign b_zero = is_zero(i_b.f);
	assign b_inf  = is_inf(i_b.f);
	assign b_nan  = is_nan(i_b.f);

	// valid tag shifts along with the data, no stall inside
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[`FPM_STAGES-2:0], i_start};
		end
	end

	assign o_valid = vld_q[`FPM_STAGES-1];

	// stage 1: unpack, classify, sign and exponent sum
	always_ff @(posedge clk) begin
		if (i_start) begin
			s1_sign    <= i_a.f.sign ^ i_b.f.sign;
			s1_exp_sum <= {1'b0, i_a.f.exp} + {1'b0, i_b.f.exp};
			// hidden one restored
			s1_man_a   <= {1'b1, i_a.f.frac};
			s1_man_b   <= {1'b1, i_b.f.frac};
			// inf times zero lands here too
			s1_nan     <= a_nan | b_nan | (a_inf & b_zero) | (a_zero & b_inf);
			s1_inf     <= a_inf | b_inf;
			s1_zero    <= a_zero | b_zero;
		end
	end

	// stage 2: 24x24 significand product
	always_ff @(posedge clk) begin
		if (vld_q[0]) begin
			s2_sign    <= s1_sign;
			s2_exp_sum <= s1_exp_sum;
			s2_prod    <= s1_man_a * s1_man_b;
			s2_nan     <= s1_nan;
			s2_inf     <= s1_inf;
			s2_zero    <= s1_zero;
		end
	end

	// stage 3: normalize by one place at most, truncate, range check
	always_comb begin
		// product in [1,4), top bit set means [2,4)
		norm    = s2_prod[47];
		exp_adj = {1'b0, s2_exp_sum} + {9'd0, norm};
		exp_unb = exp_adj - FP_BIAS;
		// biased result of 255 or more
		ovf     = exp_adj >= (FP_BIAS + {2'b00, FP_EXP_MAX});
		// biased result of 0 or less
		unf     = exp_adj <= FP_BIAS;
		flags_d = '0;
		res_d.raw    = '0;
		res_d.f.sign = s2_sign;
		if (s2_nan) begin
			res_d.raw   = FP_QNAN;
			flags_d.nan = 1'b1;
		end else if (s2_inf) begin
			// inf times finite nonzero, no flag
			res_d.f.exp = FP_EXP_MAX;
		end else if (s2_zero) begin
			flags_d.zero = 1'b1;
		end else if (ovf) begin
			res_d.f.exp      = FP_EXP_MAX;
			flags_d.overflow = 1'b1;
		end else if (unf) begin
			flags_d.underflow = 1'b1;
			flags_d.zero      = 1'b1;
		end else begin
			res_d.f.exp  = exp_unb[7:0];
			// round toward zero, dropped bits ignored
			res_d.f.frac = norm ? s2_prod[46:24] : s2_prod[45:23];
		end
	end

	// output registers hold until the next item arrives
	always_ff @(posedge clk) begin
		if (vld_q[1]) begin
			o_result <= res_d;
			o_flags  <= flags_d;
		end
	end

endmodule

`default_nettype wire

// ==== src/avs_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpm_config.svh"

module avs_ctrl import avs_pkg::*; (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic [`FPM_ADDR_W-1:0] i_address,
	input  wire logic                   i_read,
	input  wire logic                   i_write,
	input  wire logic                   i_mult_valid,
	output reg_ctrl_t                   o_reg_ctrl,
	output mm_reg_e                     o_mm_reg,
	output logic                        o_start,
	output logic                        o_waitrequest
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUSY,
		ST_CAPTURE
	} state_e;

	state_e  state, next_state;
	// decoded access target
	mm_reg_e acc_reg;

	assign acc_reg = mm_reg_e'(i_address);

	// read target for the data mux
	// no read parks on an unmapped code, so the bus sees zero
	assign o_mm_reg = i_read ? acc_reg : mm_reg_e'({`FPM_ADDR_W{1'b1}});

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		o_reg_ctrl    = '0;
		o_start       = 1'b0;
		o_waitrequest = 1'b0;
		next_state    = state;
		case (state)
			ST_IDLE: begin
				if (i_write) begin
					case (acc_reg)
						MM_OP1: o_reg_ctrl.ld_op1 = 1'b1;
						MM_OP2: o_reg_ctrl.ld_op2 = 1'b1;
						MM_START: begin
							// launch with the operands held right now
							o_start           = 1'b1;
							o_waitrequest     = 1'b1;
							o_reg_ctrl.busy   = 1'b1;
							next_state        = ST_BUSY;
						end
						// RESULT, STATUS and unmapped writes dropped
						default: ;
					endcase
				end
			end
			ST_BUSY: begin
				// master stays stalled on the START write
				o_waitrequest   = 1'b1;
				o_reg_ctrl.busy = 1'b1;
				if (i_mult_valid) begin
					next_state = ST_CAPTURE;
				end
			end
			ST_CAPTURE: begin
				// stall released, transfer completes at this edge
				o_reg_ctrl.ld_result = 1'b1;
				next_state           = ST_IDLE;
			end
			default: next_state = ST_IDLE;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/avs_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpm_config.svh"

module avs_regs import fp_pkg::*, avs_pkg::*; (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  reg_ctrl_t                   i_reg_ctrl,
	input  mm_reg_e                     i_mm_reg,
	input  wire logic [`FPM_DATA_W-1:0] i_writedata,
	input  fp_word_u                    i_mult_result,
	input  fp_flags_t                   i_mult_flags,
	output fp_word_u                    o_op1,
	output fp_word_u                    o_op2,
	output logic [`FPM_DATA_W-1:0]      o_readdata
);

	// padding above the flag bits in STATUS
	localparam int STATUS_PAD = `FPM_DATA_W - $bits(fp_flags_t);

	fp_word_u  op1_q;
	fp_word_u  op2_q;
	fp_word_u  result_q;
	fp_flags_t status_q;

	// all registers read zero after reset
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			op1_q    <= '0;
			op2_q    <= '0;
			result_q <= '0;
			status_q <= '0;
		end else begin
			if (i_reg_ctrl.ld_op1) begin
				op1_q.raw <= i_writedata;
			end
			if (i_reg_ctrl.ld_op2) begin
				op2_q.raw <= i_writedata;
			end
			// product and flags captured together
			if (i_reg_ctrl.ld_result) begin
				result_q <= i_mult_result;
				status_q <= i_mult_flags;
			end
		end
	end

	// operands go straight to the multiplier
	assign o_op1 = op1_q;
	assign o_op2 = op2_q;

	// read mux, target already decoded by the controller
	always_comb begin
		case (i_mm_reg)
			MM_OP1:    o_readdata = op1_q.raw;
			MM_OP2:    o_readdata = op2_q.raw;
			// START is the busy bit, nothing stored
			MM_START:  o_readdata = {{(`FPM_DATA_W-1){1'b0}}, i_reg_ctrl.busy};
			MM_RESULT: o_readdata = result_q.raw;
			MM_STATUS: o_readdata = {{STATUS_PAD{1'b0}}, status_q};
			// unmapped codes
			default:   o_readdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/fpm_periph.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpm_config.svh"

module fpm_periph import fp_pkg::*, avs_pkg::*; (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic [`FPM_ADDR_W-1:0] i_address,
	input  wire logic                   i_read,
	input  wire logic                   i_write,
	input  wire logic [`FPM_DATA_W-1:0] i_writedata,
	output logic [`FPM_DATA_W-1:0]      o_readdata,
	output logic                        o_waitrequest
);

	// controller to register bank
	reg_ctrl_t reg_ctrl;
	mm_reg_e   mm_reg;

	// controller to multiplier
	logic start;

	// register bank to multiplier and back
	fp_word_u  op1, op2;
	fp_word_u  mult_result;
	fp_flags_t mult_flags;
	logic      mult_valid;

	// address decode, sequencing, waitrequest
	avs_ctrl u_ctrl (
		.clk           (clk),
		.reset         (reset),
		.i_address     (i_address),
		.i_read        (i_read),
		.i_write       (i_write),
		.i_mult_valid  (mult_valid),
		.o_reg_ctrl    (reg_ctrl),
		.o_mm_reg      (mm_reg),
		.o_start       (start),
		.o_waitrequest (o_waitrequest)
	);

	// OP1, OP2, RESULT, STATUS and read mux
	avs_regs u_regs (
		.clk           (clk),
		.reset         (reset),
		.i_reg_ctrl    (reg_ctrl),
		.i_mm_reg      (mm_reg),
		.i_writedata   (i_writedata),
		.i_mult_result (mult_result),
		.i_mult_flags  (mult_flags),
		.o_op1         (op1),
		.o_op2         (op2),
		.o_readdata    (o_readdata)
	);

	// three stage single precision multiplier
	fp_mult u_mult (
		.clk      (clk),
		.reset    (reset),
		.i_start  (start),
		.i_a      (op1),
		.i_b      (op2),
		.o_valid  (mult_valid),
		.o_result (mult_result),
		.o_flags  (mult_flags)
	);

endmodule

`default_nettype wire

// ==== tb/fpm_periph_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpm_config.svh"

module fpm_periph_checker import avs_pkg::*; (
	input wire logic                   clk,
	input wire logic                   reset,
	input wire logic [`FPM_ADDR_W-1:0] i_address,
	input wire logic                   i_write,
	input wire logic                   i_waitrequest
);

	// consecutive stalled cycles before the current one
	int wait_run;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wait_run <= 0;
		end else if (i_waitrequest) begin
			wait_run <= wait_run + 1;
		end else begin
			wait_run <= 0;
		end
	end

	// only a START write may be stalled
	a_wait_start: assert property (@(posedge clk) disable iff (reset)
		i_waitrequest |-> (i_write && (i_address == MM_START)))
		else $error("waitrequest high without a START write on the bus");

	// presenting cycle plus one per pipeline stage, never more
	a_wait_bound: assert property (@(posedge clk) disable iff (reset)
		i_waitrequest |-> (wait_run < `FPM_STAGES + 1))
		else $error("waitrequest held longer than the multiplier latency");

	a_reset_quiet: assert property (@(posedge clk)
		reset |-> !i_waitrequest)
		else $error("waitrequest high during reset");

	// first cycle out of reset, controller still idle
	a_reset_exit: assert property (@(posedge clk)
		$fell(reset) |-> !i_waitrequest)
		else $error("waitrequest high in the first cycle after reset");

endmodule

bind fpm_periph fpm_periph_checker u_checker (
	.clk           (clk),
	.reset         (reset),
	.i_address     (i_address),
	.i_write       (i_write),
	.i_waitrequest (o_waitrequest)
);

`default_nettype wire

// ==== tb/fpm_periph_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fpm_config.svh"

module fpm_periph_tb import fp_pkg::*, avs_pkg::*; ();

	localparam int CLK_PERIOD  = 100;
	localparam int DRIVE_DLY   = 1;
	localparam int N_ROWS      = 17;
	localparam int N_RAND      = 8;
	// budget per test in cycles
	localparam int TIMEOUT_CYC = (N_ROWS + N_RAND) * 40;

	// operands of one product with expected RESULT and STATUS flags
	typedef struct packed {
		logic [31:0] op1;
		logic [31:0] op2;
		logic [31:0] res;
		fp_flags_t   flags;
	} vec_t;

	logic                   clk;
	logic                   reset;
	logic [`FPM_ADDR_W-1:0] addr;
	logic                   rd;
	logic                   wr;
	logic [`FPM_DATA_W-1:0] wdata;
	logic [`FPM_DATA_W-1:0] rdata;
	logic                   waitreq;

	vec_t        vec_tab [N_ROWS];
	logic [31:0] lcg_state;
	int          err_count;

	fpm_periph DUT (
		.clk           (clk),
		.reset         (reset),
		.i_address     (addr),
		.i_read        (rd),
		.i_write       (wr),
		.i_writedata   (wdata),
		.o_readdata    (rdata),
		.o_waitrequest (waitreq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// no test should come close to this
	initial begin
		#(TIMEOUT_CYC * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			err_count++;
			$display("ERR t=%0t %s: got %h expected %h", $time, what, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// truncated products worked out by hand
	task automatic fill_table();
		// normal operands with flags clear
		vec_tab[0]  = '{32'h3FC00000, 32'h40000000, 32'h40400000, 4'b0000};
		vec_tab[1]  = '{32'hBFC00000, 32'h40000000, 32'hC0400000, 4'b0000};
		// 2.25 needs the one-place shift
		vec_tab[2]  = '{32'h3FC00000, 32'h3FC00000, 32'h40100000, 4'b0000};
		vec_tab[3]  = '{32'h40400000, 32'h3F000000, 32'h3FC00000, 4'b0000};
		// half-ulp tail dropped where nearest-even would give ...02
		vec_tab[4]  = '{32'h3FC00000, 32'h3F800001, 32'h3FC00001, 4'b0000};
		vec_tab[5]  = '{32'h3FFFFFFF, 32'h3FFFFFFF, 32'h407FFFFE, 4'b0000};
		// overflow to signed inf
		vec_tab[6]  = '{32'h7F000000, 32'h40000000, 32'h7F800000, 4'b1000};
		vec_tab[7]  = '{32'hFF000000, 32'h7F000000, 32'hFF800000, 4'b1000};
		// underflow to signed zero
		vec_tab[8]  = '{32'h00800000, 32'h3F000000, 32'h00000000, 4'b0110};
		vec_tab[9]  = '{32'h80800000, 32'h3F000000, 32'h80000000, 4'b0110};
		// zero operands keep the sign
		vec_tab[10] = '{32'h00000000, 32'h40400000, 32'h00000000, 4'b0010};
		vec_tab[11] = '{32'h80000000, 32'h40000000, 32'h80000000, 4'b0010};
		// subnormal counts as zero
		vec_tab[12] = '{32'h00400000, 32'h40000000, 32'h00000000, 4'b0010};
		// nan inputs and inf times zero
		vec_tab[13] = '{32'h7FC00001, 32'h3F800000, 32'h7FC00000, 4'b0001};
		vec_tab[14] = '{32'hFFA00000, 32'h40000000, 32'h7FC00000, 4'b0001};
		vec_tab[15] = '{32'h7F800000, 32'h00000000, 32'h7FC00000, 4'b0001};
		// inf times finite raises no flag
		vec_tab[16] = '{32'h7F800000, 32'hC0000000, 32'hFF800000, 4'b0000};
	endtask

	// called just after a rising edge and returns just after the completing edge
	task automatic write_reg(input logic [`FPM_ADDR_W-1:0] a, input logic [31:0] d,
			output int stalls);
		stalls = 0;
		addr   = a;
		wdata  = d;
		wr     = 1'b1;
		@(negedge clk);
		// count stalled cycles after the presenting one
		while (waitreq) begin
			@(negedge clk);
			if (waitreq) begin
				stalls++;
			end
		end
		@(posedge clk);
		#(DRIVE_DLY);
		wr = 1'b0;
	endtask

	task automatic read_reg(input logic [`FPM_ADDR_W-1:0] a, output logic [31:0] d);
		addr = a;
		rd   = 1'b1;
		// combinational read data sampled mid-cycle
		@(negedge clk);
		d = rdata;
		check_equal({31'd0, waitreq}, 32'd0, "read stalled");
		@(posedge clk);
		#(DRIVE_DLY);
		rd = 1'b0;
	endtask

	initial begin
		int          i;
		int          stalls;
		logic [31:0] rv;
		logic [31:0] w1;
		logic [31:0] w2;
		addr      = '0;
		rd        = 1'b0;
		wr        = 1'b0;
		wdata     = '0;
		reset     = 1'b1;
		lcg_state = 32'h1ae0;
		err_count = 0;
		fill_table();
		repeat (8) @(posedge clk);
		#(DRIVE_DLY);
		reset = 1'b0;

		// all registers clear and bus idle
		check_equal({31'd0, waitreq}, 32'd0, "waitrequest after reset");
		for (i = 0; i < 5; i++) begin
			read_reg(3'(i), rv);
			check_equal(rv, 32'd0, $sformatf("register %0d after reset", i));
		end

		// operand readback with random words
		for (i = 0; i < N_RAND; i++) begin
			w1 = lcg_next();
			w2 = lcg_next();
			write_reg(MM_OP1, w1, stalls);
			check_equal(stalls, 32'd0, "OP1 write stalled");
			write_reg(MM_OP2, w2, stalls);
			check_equal(stalls, 32'd0, "OP2 write stalled");
			read_reg(MM_OP1, rv);
			check_equal(rv, w1, $sformatf("OP1 readback %0d", i));
			read_reg(MM_OP2, rv);
			check_equal(rv, w2, $sformatf("OP2 readback %0d", i));
		end

		// product table
		for (i = 0; i < N_ROWS; i++) begin
			write_reg(MM_OP1, vec_tab[i].op1, stalls);
			write_reg(MM_OP2, vec_tab[i].op2, stalls);
			write_reg(MM_START, 32'd1, stalls);
			check_equal(stalls, `FPM_STAGES, $sformatf("row %0d START stall", i));
			read_reg(MM_RESULT, rv);
			check_equal(rv, vec_tab[i].res, $sformatf("row %0d RESULT", i));
			read_reg(MM_STATUS, rv);
			check_equal(rv, {28'd0, vec_tab[i].flags}, $sformatf("row %0d STATUS", i));
			read_reg(MM_START, rv);
			check_equal(rv, 32'd0, $sformatf("row %0d START after done", i));
		end

		// back to back products take the newest operands
		write_reg(MM_OP1, 32'h3FC00000, stalls);
		write_reg(MM_OP2, 32'h40000000, stalls);
		write_reg(MM_START, 32'd1, stalls);
		check_equal(stalls, `FPM_STAGES, "first START stall");
		write_reg(MM_OP2, 32'h3FC00000, stalls);
		write_reg(MM_START, 32'd1, stalls);
		check_equal(stalls, `FPM_STAGES, "second START stall");
		read_reg(MM_RESULT, rv);
		check_equal(rv, 32'h40100000, "second product");
		write_reg(MM_OP1, 32'hC0400000, stalls);
		write_reg(MM_START, 32'd1, stalls);
		check_equal(stalls, `FPM_STAGES, "third START stall");
		read_reg(MM_RESULT, rv);
		check_equal(rv, 32'hC0900000, "third product");

		// RESULT, STATUS and unmapped writes dropped
		w1 = lcg_next();
		write_reg(MM_RESULT, w1, stalls);
		write_reg(MM_STATUS, ~w1, stalls);
		write_reg(3'd5, w1, stalls);
		read_reg(MM_RESULT, rv);
		check_equal(rv, 32'hC0900000, "RESULT after bus write");
		read_reg(MM_STATUS, rv);
		check_equal(rv, 32'd0, "STATUS after bus write");
		read_reg(MM_OP1, rv);
		check_equal(rv, 32'hC0400000, "OP1 after unmapped write");
		read_reg(MM_OP2, rv);
		check_equal(rv, 32'h3FC00000, "OP2 after unmapped write");
		for (i = 5; i < 8; i++) begin
			read_reg(3'(i), rv);
			check_equal(rv, 32'd0, $sformatf("unmapped address %0d", i));
		end

		if (err_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+src
src/fp_pkg.sv
src/avs_pkg.sv
src/fp_mult.sv
src/avs_ctrl.sv
src/avs_regs.sv
src/fpm_periph.sv
tb/fpm_periph_checker.sv
tb/fpm_periph_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module fpm_periph_tb -Mdir obj_dir

# a failing run still prints, the grep decides
out=$(./obj_dir/Vfpm_periph_tb 2>&1) || true
echo "$out"

if echo "$out" | grep -Fqx "=== PASS ==="; then
	exit 0
fi
exit 1
